//--- Bender.yml
package:
  name: drone_rate_loop

sources:
  - include_dirs:
      - design
    files:
      - design/rate_loop_pkg.sv
      - design/error_integrator.sv
      - design/axis_pid.sv
      - design/rate_sequencer.sv
      - design/rate_loop_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - tb/clk_rst_gen.sv
      - tb/rate_loop_tb.sv

//--- design/axis_pid.sv
`timescale 1ns/1ps
`include "rate_loop_params.svh"

module axis_pid (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  rate_loop_pkg::rate_t target_rotation,
	input  rate_loop_pkg::rate_t actual_rotation,
	input  rate_loop_pkg::rate_t angle_error,
	input  logic                 start_flag,
	input  logic                 wait_flag,
	output rate_loop_pkg::rate_t rate_out,
	output logic                 pid_complete,
	output logic                 pid_active
);
	import rate_loop_pkg::*;

	localparam acc_t k_p = acc_t'(`K_P);
	localparam acc_t k_i = acc_t'(`K_I);
	localparam acc_t k_d = acc_t'(`K_D);

	localparam acc_t rate_max = acc_t'(`RATE_LIMIT);
	localparam acc_t rate_min = -acc_t'(`RATE_LIMIT);

	pid_state_t state;
	pid_state_t next_state;

	// current and previous sample error
	rate_t rotation_error;
	rate_t prev_rotation_error;

	// terms, kept wide until the clamp
	acc_t rotation_integral;
	acc_t rotation_proportional;
	acc_t error_change;
	acc_t rotation_derivative;
	acc_t rotation_total;

	always_comb begin
		case (state)
			st_wait:     next_state = start_flag ? st_calc1 : st_wait;
			st_calc1:    next_state = st_calc2;
			st_calc2:    next_state = st_calc3;
			st_calc3:    next_state = st_calc4;
			st_calc4:    next_state = st_complete;
			st_complete: next_state = wait_flag ? st_wait : st_complete;
			default:     next_state = st_wait;
		endcase
	end

	// state, status flags, error history and the clamped command
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state               <= st_wait;
			pid_active          <= 1'b0;
			pid_complete        <= 1'b0;
			rate_out            <= '0;
			rotation_error      <= '0;
			prev_rotation_error <= '0;
		end else begin
			state <= next_state;
			case (state)
				st_wait: begin
					// idle reads as complete but not active
					pid_active   <= 1'b0;
					pid_complete <= 1'b1;
				end
				st_calc1: begin
					pid_active          <= 1'b1;
					pid_complete        <= 1'b0;
					prev_rotation_error <= rotation_error;
					rotation_error      <= target_rotation - actual_rotation;
				end
				st_calc2, st_calc3, st_calc4: begin
					pid_active   <= 1'b1;
					pid_complete <= 1'b0;
				end
				st_complete: begin
					pid_active   <= 1'b1;
					pid_complete <= 1'b1;
					if (rotation_total < rate_min)
						rate_out <= rate_t'(rate_min);
					else if (rotation_total > rate_max)
						rate_out <= rate_t'(rate_max);
					else
						rate_out <= rate_t'(rotation_total);
				end
				default: begin
					pid_active   <= 1'b0;
					pid_complete <= 1'b0;
				end
			endcase
		end
	end

	// datapath, one step per calc state
	always_ff @(posedge us_clk) begin
		case (state)
			st_calc1: begin
				rotation_integral <= k_i * acc_t'(angle_error);
			end
			st_calc2: begin
				rotation_proportional <= k_p * acc_t'(rotation_error);
				// previous minus current
				error_change <= acc_t'(prev_rotation_error) - acc_t'(rotation_error);
			end
			st_calc3: begin
				rotation_derivative <= k_d * error_change;
			end
			st_calc4: begin
				rotation_total <= rotation_proportional + rotation_integral
					+ rotation_derivative;
			end
			default: begin
			end
		endcase
	end

	// sequencer must only start an idle PID
	a_start_in_wait: assert property (@(posedge us_clk) disable iff (!resetn)
		start_flag |-> state == st_wait);

	a_rate_in_limit: assert property (@(posedge us_clk) disable iff (!resetn)
		pid_active && pid_complete |-> acc_t'(rate_out) >= rate_min
			&& acc_t'(rate_out) <= rate_max);

	a_state_onehot: assert property (@(posedge us_clk) disable iff (!resetn)
		$onehot(state));

endmodule

//--- design/error_integrator.sv
`timescale 1ns/1ps
`include "rate_loop_params.svh"

module error_integrator (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 integrate,
	input  rate_loop_pkg::rate_t target_rotation,
	input  rate_loop_pkg::rate_t actual_rotation,
	output rate_loop_pkg::rate_t angle_error
);
	import rate_loop_pkg::*;

	localparam acc_t err_max = acc_t'(`ANGLE_ERR_LIMIT);
	localparam acc_t err_min = -acc_t'(`ANGLE_ERR_LIMIT);

	rate_t acc_q;
	acc_t  sum;
	rate_t sum_sat;

	// wide sum so the rate difference cannot wrap
	always_comb begin
		sum = acc_t'(acc_q) + acc_t'(target_rotation) - acc_t'(actual_rotation);
	end

	always_comb begin
		if (sum > err_max)
			sum_sat = rate_t'(err_max);
		else if (sum < err_min)
			sum_sat = rate_t'(err_min);
		else
			sum_sat = rate_t'(sum);
	end

	// only reset clears the running error
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			acc_q <= '0;
		else if (integrate)
			acc_q <= sum_sat;
	end

	assign angle_error = acc_q;

	a_acc_in_limit: assert property (@(posedge us_clk) disable iff (!resetn)
		acc_t'(acc_q) >= err_min && acc_t'(acc_q) <= err_max);

endmodule

//--- design/rate_loop_params.svh
`ifndef RATE_LOOP_PARAMS_SVH
`define RATE_LOOP_PARAMS_SVH

// word widths
`define RATE_WIDTH 16
`define ACC_WIDTH 32

// roll, pitch and yaw
`define N_AXES 3

// signed integer gains, applied as plain multiplies
`define K_P 2
`define K_I 1
`define K_D 1

// symmetric clamp on every rate command
`define RATE_LIMIT 1024

// symmetric saturation of the accumulated error
`define ANGLE_ERR_LIMIT 4096

`endif

//--- design/rate_loop_pkg.sv
`include "rate_loop_params.svh"

package rate_loop_pkg;

	// targets, measurements, errors and commands
	typedef logic signed [`RATE_WIDTH-1:0] rate_t;

	// products and their sum before the clamp
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	// one-hot PID sequence
	typedef enum logic [5:0] {
		st_wait     = 6'b000001,
		st_calc1    = 6'b000010,
		st_calc2    = 6'b000100,
		st_calc3    = 6'b001000,
		st_calc4    = 6'b010000,
		st_complete = 6'b100000
	} pid_state_t;

	typedef logic [1:0] axis_idx_t;

	localparam axis_idx_t axis_roll  = 2'd0;
	localparam axis_idx_t axis_pitch = 2'd1;
	localparam axis_idx_t axis_yaw   = 2'd2;

endpackage

//--- design/rate_loop_top.sv
`timescale 1ns/1ps
`include "rate_loop_params.svh"

module rate_loop_top (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 sample_valid,
	output logic                 sample_ready,
	input  rate_loop_pkg::rate_t target_roll,
	input  rate_loop_pkg::rate_t target_pitch,
	input  rate_loop_pkg::rate_t target_yaw,
	input  rate_loop_pkg::rate_t meas_roll,
	input  rate_loop_pkg::rate_t meas_pitch,
	input  rate_loop_pkg::rate_t meas_yaw,
	output logic                 cmd_valid,
	input  logic                 cmd_ready,
	output rate_loop_pkg::rate_t cmd_roll,
	output rate_loop_pkg::rate_t cmd_pitch,
	output rate_loop_pkg::rate_t cmd_yaw
);
	import rate_loop_pkg::*;

	// per-axis signals, indexed by axis_idx_t
	rate_t lat_target [`N_AXES];
	rate_t lat_meas [`N_AXES];
	rate_t angle_err [`N_AXES];
	rate_t rate_cmd [`N_AXES];

	logic [`N_AXES-1:0] pid_complete;
	logic [`N_AXES-1:0] pid_active;
	logic               pid_complete_all;
	logic               pid_active_all;
	logic               integrate;
	logic               start_flag;
	logic               wait_flag;

	assign pid_complete_all = &pid_complete;
	assign pid_active_all   = &pid_active;

	rate_sequencer seq_i (
		.us_clk           (us_clk),
		.resetn           (resetn),
		.sample_valid     (sample_valid),
		.sample_ready     (sample_ready),
		.target_roll      (target_roll),
		.target_pitch     (target_pitch),
		.target_yaw       (target_yaw),
		.meas_roll        (meas_roll),
		.meas_pitch       (meas_pitch),
		.meas_yaw         (meas_yaw),
		.lat_target_roll  (lat_target[axis_roll]),
		.lat_target_pitch (lat_target[axis_pitch]),
		.lat_target_yaw   (lat_target[axis_yaw]),
		.lat_meas_roll    (lat_meas[axis_roll]),
		.lat_meas_pitch   (lat_meas[axis_pitch]),
		.lat_meas_yaw     (lat_meas[axis_yaw]),
		.integrate        (integrate),
		.start_flag       (start_flag),
		.wait_flag        (wait_flag),
		.pid_complete_all (pid_complete_all),
		.pid_active_all   (pid_active_all),
		.rate_roll        (rate_cmd[axis_roll]),
		.rate_pitch       (rate_cmd[axis_pitch]),
		.rate_yaw         (rate_cmd[axis_yaw]),
		.cmd_valid        (cmd_valid),
		.cmd_ready        (cmd_ready),
		.cmd_roll         (cmd_roll),
		.cmd_pitch        (cmd_pitch),
		.cmd_yaw          (cmd_yaw)
	);

	for (genvar g = 0; g < `N_AXES; g++) begin : g_axis
		localparam axis_idx_t axis = axis_idx_t'(g);

		error_integrator integ_i (
			.us_clk          (us_clk),
			.resetn          (resetn),
			.integrate       (integrate),
			.target_rotation (lat_target[axis]),
			.actual_rotation (lat_meas[axis]),
			.angle_error     (angle_err[axis])
		);

		axis_pid pid_i (
			.us_clk          (us_clk),
			.resetn          (resetn),
			.target_rotation (lat_target[axis]),
			.actual_rotation (lat_meas[axis]),
			.angle_error     (angle_err[axis]),
			.start_flag      (start_flag),
			.wait_flag       (wait_flag),
			.rate_out        (rate_cmd[axis]),
			.pid_complete    (pid_complete[axis]),
			.pid_active      (pid_active[axis])
		);
	end

endmodule

//--- design/rate_sequencer.sv
`timescale 1ns/1ps
`include "rate_loop_params.svh"

module rate_sequencer (
	input  logic                 us_clk,
	input  logic                 resetn,
	input  logic                 sample_valid,
	output logic                 sample_ready,
	input  rate_loop_pkg::rate_t target_roll,
	input  rate_loop_pkg::rate_t target_pitch,
	input  rate_loop_pkg::rate_t target_yaw,
	input  rate_loop_pkg::rate_t meas_roll,
	input  rate_loop_pkg::rate_t meas_pitch,
	input  rate_loop_pkg::rate_t meas_yaw,
	output rate_loop_pkg::rate_t lat_target_roll,
	output rate_loop_pkg::rate_t lat_target_pitch,
	output rate_loop_pkg::rate_t lat_target_yaw,
	output rate_loop_pkg::rate_t lat_meas_roll,
	output rate_loop_pkg::rate_t lat_meas_pitch,
	output rate_loop_pkg::rate_t lat_meas_yaw,
	output logic                 integrate,
	output logic                 start_flag,
	output logic                 wait_flag,
	input  logic                 pid_complete_all,
	input  logic                 pid_active_all,
	input  rate_loop_pkg::rate_t rate_roll,
	input  rate_loop_pkg::rate_t rate_pitch,
	input  rate_loop_pkg::rate_t rate_yaw,
	output logic                 cmd_valid,
	input  logic                 cmd_ready,
	output rate_loop_pkg::rate_t cmd_roll,
	output rate_loop_pkg::rate_t cmd_pitch,
	output rate_loop_pkg::rate_t cmd_yaw
);

	localparam logic [2:0] s_idle  = 3'd0;
	localparam logic [2:0] s_integ = 3'd1;
	localparam logic [2:0] s_start = 3'd2;
	localparam logic [2:0] s_run   = 3'd3;
	localparam logic [2:0] s_out   = 3'd4;
	localparam logic [2:0] s_rel   = 3'd5;
	localparam logic [2:0] s_drain = 3'd6;

	logic [2:0] state;
	logic [2:0] next_state;
	logic       pids_done;

	// all three in complete, status already registered
	assign pids_done = pid_complete_all && pid_active_all;

	always_comb begin
		case (state)
			s_idle:  next_state = sample_valid ? s_integ : s_idle;
			s_integ: next_state = s_start;
			s_start: next_state = s_run;
			s_run:   next_state = pids_done ? s_out : s_run;
			s_out:   next_state = cmd_ready ? s_rel : s_out;
			s_rel:   next_state = s_drain;
			// lets the PID status fall back to idle values
			s_drain: next_state = s_idle;
			default: next_state = s_idle;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= s_idle;
		else
			state <= next_state;
	end

	assign sample_ready = state == s_idle;
	assign integrate    = state == s_integ;
	assign start_flag   = state == s_start;
	assign cmd_valid    = state == s_out;
	assign wait_flag    = state == s_rel;

	// sample held for the whole pass
	always_ff @(posedge us_clk) begin
		if (sample_valid && sample_ready) begin
			lat_target_roll  <= target_roll;
			lat_target_pitch <= target_pitch;
			lat_target_yaw   <= target_yaw;
			lat_meas_roll    <= meas_roll;
			lat_meas_pitch   <= meas_pitch;
			lat_meas_yaw     <= meas_yaw;
		end
	end

	always_ff @(posedge us_clk) begin
		if (state == s_run && pids_done) begin
			cmd_roll  <= rate_roll;
			cmd_pitch <= rate_pitch;
			cmd_yaw   <= rate_yaw;
		end
	end

	a_cmd_hold: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_roll)
			&& $stable(cmd_pitch) && $stable(cmd_yaw));

	a_one_in_flight: assert property (@(posedge us_clk) disable iff (!resetn)
		!(sample_ready && cmd_valid));

endmodule

//--- drone_rate_loop.f
+incdir+design
design/rate_loop_pkg.sv
design/error_integrator.sv
design/axis_pid.sv
design/rate_sequencer.sv
design/rate_loop_top.sv
tb/clk_rst_gen.sv
tb/rate_loop_tb.sv

//--- tb/clk_rst_gen.sv
`timescale 1ns/1ps

module clk_rst_gen (
	output logic us_clk,
	output logic resetn
);

	// 10 ns period
	initial begin
		us_clk = 1'b0;
		forever #5 us_clk = ~us_clk;
	end

	// low for three rising edges, released just after the third
	initial begin
		resetn = 1'b0;
		repeat (3) @(posedge us_clk);
		#1;
		resetn = 1'b1;
	end

endmodule

//--- tb/rate_loop_tb.sv
`timescale 1ns/1ps
`include "rate_loop_params.svh"

module rate_loop_tb;
	import rate_loop_pkg::*;

	localparam int num_rows   = 12;
	localparam int wait_limit = 50;
	localparam int latency    = 8;

	logic  us_clk;
	logic  resetn;
	logic  sample_valid;
	logic  sample_ready;
	rate_t target_roll;
	rate_t target_pitch;
	rate_t target_yaw;
	rate_t meas_roll;
	rate_t meas_pitch;
	rate_t meas_yaw;
	logic  cmd_valid;
	logic  cmd_ready;
	rate_t cmd_roll;
	rate_t cmd_pitch;
	rate_t cmd_yaw;

	// target and measured rate of roll, pitch and yaw, then the expected commands
	int stim_table [num_rows][9] = '{
		'{   10,   0,   -20,  -5,    5,    0,    20,   -30,   10},
		'{   25,   5,   -10, -10,   40,   12,    60,   -30,   66},
		'{  100,  60,    30,  50,   -8,    8,   130,   -55,   29},
		'{ 3000,   0, -2500,   0,    0,    0,  1024, -1024,    1},
		'{ 3000,   0, -2500,   0,   16,    4,  1024, -1024,   41},
		'{ 3000,   0, -2500,   0,  600, -100,  1024, -1024, 1024},
		'{-2000,   0,  1800,   0,    0,    0,  1024, -1024, 1024},
		'{-1500,   0,  1500,   0, -300, -100, -1024,  1024,  329},
		'{    0,   0,     0,   0,  -40,    0,  -904,   704,  249},
		'{   20,  10,   -15,   5,   64,    0,   616,  -836,  577},
		'{   20,  10,   -15,   5,   64,    0,   636,  -876,  745},
		'{   20,  10,   -15,   5, -128,    0,   646,  -896,  425}
	};

	string axis_name [`N_AXES] = '{"cmd_roll", "cmd_pitch", "cmd_yaw"};

	// reference model state carried across rows
	int model_acc [`N_AXES];
	int model_prev [`N_AXES];
	int model_cmd [`N_AXES];
	int dut_cmd [`N_AXES];
	int sat_hits;
	int clamp_high_hits;
	int clamp_low_hits;

	int          value_errors;
	int          other_errors;
	logic        timed_out;
	logic [15:0] lfsr;

	clk_rst_gen clk_gen_i (
		.us_clk (us_clk),
		.resetn (resetn)
	);

	rate_loop_top dut_i (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.target_roll  (target_roll),
		.target_pitch (target_pitch),
		.target_yaw   (target_yaw),
		.meas_roll    (meas_roll),
		.meas_pitch   (meas_pitch),
		.meas_yaw     (meas_yaw),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.cmd_roll     (cmd_roll),
		.cmd_pitch    (cmd_pitch),
		.cmd_yaw      (cmd_yaw)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic draw_bits(input int n, output int value);
		int i;
		value = 0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// inputs change 1 ns after the edge
	task automatic next_cycle();
		@(posedge us_clk);
		#1;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			value_errors++;
			$display("** Error at %0t: %s expected %0d, actual %0d", $time, name,
				expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		other_errors++;
		timed_out = 1'b1;
		$display("timeout at %0t: %s for %0d cycles", $time, what, wait_limit);
	endtask

	// integrate, then P + I + D with previous minus current, then clamp
	task automatic model_step(input int row);
		int a;
		int err;
		int sum;
		int total;
		for (a = 0; a < `N_AXES; a++) begin
			err = stim_table[row][2*a] - stim_table[row][2*a+1];
			sum = model_acc[a] + err;
			if (sum > `ANGLE_ERR_LIMIT) begin
				sum = `ANGLE_ERR_LIMIT;
				sat_hits++;
			end else if (sum < -`ANGLE_ERR_LIMIT) begin
				sum = -`ANGLE_ERR_LIMIT;
				sat_hits++;
			end
			model_acc[a] = sum;
			total = `K_I * model_acc[a] + `K_P * err + `K_D * (model_prev[a] - err);
			model_prev[a] = err;
			if (total > `RATE_LIMIT) begin
				total = `RATE_LIMIT;
				clamp_high_hits++;
			end else if (total < -`RATE_LIMIT) begin
				total = -`RATE_LIMIT;
				clamp_low_hits++;
			end
			model_cmd[a] = total;
		end
	endtask

	task automatic drive_sample(input int row);
		target_roll  = rate_t'(stim_table[row][0]);
		meas_roll    = rate_t'(stim_table[row][1]);
		target_pitch = rate_t'(stim_table[row][2]);
		meas_pitch   = rate_t'(stim_table[row][3]);
		target_yaw   = rate_t'(stim_table[row][4]);
		meas_yaw     = rate_t'(stim_table[row][5]);
	endtask

	// extreme values that would wreck every axis if latched
	task automatic drive_competing_sample();
		target_roll  = rate_t'(32767);
		meas_roll    = rate_t'(-32768);
		target_pitch = rate_t'(-32768);
		meas_pitch   = rate_t'(32767);
		target_yaw   = rate_t'(32767);
		meas_yaw     = rate_t'(-32768);
	endtask

	task automatic read_commands();
		dut_cmd[0] = cmd_roll;
		dut_cmd[1] = cmd_pitch;
		dut_cmd[2] = cmd_yaw;
	endtask

	task automatic run_row(input int row);
		int t;
		int lat;
		int delay;
		int a;
		int held [`N_AXES];
		model_step(row);
		for (a = 0; a < `N_AXES; a++) begin
			assert (stim_table[row][6+a] == model_cmd[a]) else begin
				other_errors++;
				$display("table row %0d: expected %s does not match the reference model",
					row, axis_name[a]);
			end
		end
		drive_sample(row);
		sample_valid = 1'b1;
		t = 0;
		while (!sample_ready && t < wait_limit) begin
			next_cycle();
			t++;
		end
		if (!sample_ready) begin
			sample_valid = 1'b0;
			report_timeout("sample_ready stayed low");
			return;
		end
		// sample transfers on this edge
		next_cycle();
		// a new sample stays offered while this one is in flight
		drive_competing_sample();
		lat = 0;
		while (!cmd_valid && lat < wait_limit) begin
			assert (!sample_ready) else begin
				other_errors++;
				$display("sample_ready rose at %0t while a sample was in flight", $time);
			end
			next_cycle();
			lat++;
		end
		if (!cmd_valid) begin
			sample_valid = 1'b0;
			report_timeout("cmd_valid stayed low");
			return;
		end
		check_value("cmd_valid latency", latency, lat);
		read_commands();
		for (a = 0; a < `N_AXES; a++) begin
			check_value(axis_name[a], model_cmd[a], dut_cmd[a]);
			held[a] = dut_cmd[a];
		end
		// back-pressure while the new sample is still offered
		draw_bits(3, delay);
		repeat (delay) begin
			next_cycle();
			read_commands();
			check_value("cmd_valid", 1, cmd_valid);
			check_value("sample_ready", 0, sample_ready);
			for (a = 0; a < `N_AXES; a++)
				check_value(axis_name[a], held[a], dut_cmd[a]);
		end
		sample_valid = 1'b0;
		cmd_ready    = 1'b1;
		next_cycle();
		cmd_ready = 1'b0;
		check_value("cmd_valid", 0, cmd_valid);
	endtask

	initial begin
		int row;
		int t;
		sample_valid = 1'b0;
		cmd_ready    = 1'b0;
		drive_sample(0);
		lfsr            = 16'd49878;
		value_errors    = 0;
		other_errors    = 0;
		timed_out       = 1'b0;
		sat_hits        = 0;
		clamp_high_hits = 0;
		clamp_low_hits  = 0;
		for (row = 0; row < `N_AXES; row++) begin
			model_acc[row]  = 0;
			model_prev[row] = 0;
		end

		t = 0;
		while (!resetn && t < wait_limit) begin
			@(posedge us_clk);
			t++;
		end
		if (!resetn)
			report_timeout("resetn stayed low");
		next_cycle();
		check_value("sample_ready", 1, sample_ready);
		check_value("cmd_valid", 0, cmd_valid);

		for (row = 0; row < num_rows && !timed_out; row++)
			run_row(row);

		// the table must reach integrator saturation and both clamps
		if (!timed_out) begin
			assert (sat_hits > 0) else begin
				other_errors++;
				$display("no row drove an integrator into saturation");
			end
			assert (clamp_high_hits > 0 && clamp_low_hits > 0) else begin
				other_errors++;
				$display("rows did not reach both the upper and the lower command clamp");
			end
		end

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
